// ==== letc_pkg.sv ====
`default_nettype none

package letc_pkg;

    // Data word and physical address
    typedef logic [31:0] word_t;

    localparam int PADDR_WIDTH = 32;
    typedef logic [PADDR_WIDTH-1:0] paddr_t;

    // Access size requested by a core requestor
    typedef enum logic [1:0] {
        SIZE_BYTE     = 2'b00,
        SIZE_HALFWORD = 2'b01,
        SIZE_WORD     = 2'b10
    } size_e;

    // One data word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } lane_u;

    // MMU walker, caches, uncached access
    localparam int NUM_REQUESTORS = 3;
    localparam int REQ_IDX_WIDTH  = 2;

    // Subordinate memory depth, indexed by address bits 9:2
    localparam int MEM_WORDS = 256;

endpackage : letc_pkg

`default_nettype wire

// ==== axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    localparam int IDWIDTH  = 4;
    localparam int LENWIDTH = 8;

    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } burst_e;

    // Single ID used by the core manager
    localparam logic [IDWIDTH-1:0] AXI_ID = '0;

    localparam logic [2:0] AXI_SIZE_WORD = 3'b010; // 4 bytes per beat

    // Response codes
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage : axi_pkg

`default_nettype wire

// ==== letc_core_lane_fmt.sv ====
`timescale 1ns/1ps
`default_nettype none

module letc_core_lane_fmt (
    input  letc_pkg::size_e size,
    input  logic [1:0]      byte_offset,  // Low address bits of the access
    input  letc_pkg::word_t wdata_in,     // Requestor write data, right aligned
    input  letc_pkg::word_t axi_rdata,    // Full word from the bus
    output logic [3:0]      wstrb,
    output letc_pkg::word_t axi_wdata,
    output letc_pkg::word_t rdata_out     // Zero extended read result
);
    import letc_pkg::*;

    lane_u wlane;
    lane_u rlane;

    // Write side
    always_comb begin
        wstrb       = 4'b1111;
        wlane.bytes = wdata_in;
        unique case (size)
            SIZE_BYTE: begin
                wstrb       = 4'b0001 << byte_offset;  // One-hot lane
                wlane.bytes = {4{wdata_in[7:0]}};      // Same byte in every lane
            end
            SIZE_HALFWORD: begin
                wstrb        = byte_offset[1] ? 4'b1100 : 4'b0011;
                wlane.halves = {2{wdata_in[15:0]}};
            end
            default: begin
                // Full word, strobes and data as set above
            end
        endcase
    end

    assign axi_wdata = wlane;

    // Read side, pick the addressed lane out of the bus word
    assign rlane = axi_rdata;

    always_comb begin
        unique case (size)
            SIZE_BYTE:     rdata_out = {24'h0, rlane.bytes[byte_offset]};
            SIZE_HALFWORD: rdata_out = {16'h0, rlane.halves[byte_offset[1]]};
            default:       rdata_out = axi_rdata;  // Word passes through
        endcase
    end

endmodule : letc_core_lane_fmt

`default_nettype wire

// ==== letc_core_axi_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module letc_core_axi_fsm (
    input  logic i_clk,
    input  logic i_rst_n,

    // Requestor side, one lane each
    input  logic [letc_pkg::NUM_REQUESTORS-1:0]              limp_valid,
    input  logic [letc_pkg::NUM_REQUESTORS-1:0]              limp_wen_nren,
    input  letc_pkg::size_e [letc_pkg::NUM_REQUESTORS-1:0]   limp_size,
    input  letc_pkg::paddr_t [letc_pkg::NUM_REQUESTORS-1:0]  limp_addr,
    input  letc_pkg::word_t [letc_pkg::NUM_REQUESTORS-1:0]   limp_wdata,
    output logic [letc_pkg::NUM_REQUESTORS-1:0]              limp_ready,
    output letc_pkg::word_t                                  limp_rdata,  // Shared by all

    // AXI manager outputs
    output logic [axi_pkg::IDWIDTH-1:0]  awid,
    output letc_pkg::paddr_t             awaddr,
    output logic [axi_pkg::LENWIDTH-1:0] awlen,
    output logic [2:0]                   awsize,
    output axi_pkg::burst_e              awburst,
    output logic                         awvalid,
    output letc_pkg::word_t              wdata,
    output logic [3:0]                   wstrb,
    output logic                         wvalid,
    output logic                         bready,
    output logic [axi_pkg::IDWIDTH-1:0]  arid,
    output letc_pkg::paddr_t             araddr,
    output logic [axi_pkg::LENWIDTH-1:0] arlen,
    output logic [2:0]                   arsize,
    output axi_pkg::burst_e              arburst,
    output logic                         arvalid,
    output logic                         rready,

    // AXI manager inputs
    input  logic                         awready,
    input  logic                         wready,
    input  logic                         bvalid,
    input  logic [axi_pkg::IDWIDTH-1:0]  bid,
    input  logic [1:0]                   bresp,   // Not acted on
    input  logic                         arready,
    input  logic                         rvalid,
    input  logic [axi_pkg::IDWIDTH-1:0]  rid,
    input  letc_pkg::word_t              rdata,
    input  logic [1:0]                   rresp    // Not acted on
);
    import letc_pkg::*;
    import axi_pkg::*;

    // Mealy FSM, one access in flight
    typedef enum logic [2:0] {
        IDLE,
        SEND_RADDR,
        GET_RDATA,
        SEND_WADDR,
        SEND_WDATA,
        GET_BRESP
    } state_e;

    state_e state;
    state_e next_state;

    logic [REQ_IDX_WIDTH-1:0] sel_idx;    // Priority pick, valid in IDLE
    logic [REQ_IDX_WIDTH-1:0] grant_q;    // Locked owner outside IDLE
    logic [REQ_IDX_WIDTH-1:0] cur_idx;
    logic                     any_valid;
    logic                     cur_wen_nren;
    size_e                    cur_size;
    paddr_t                   cur_addr;
    word_t                    cur_wdata;
    logic                     data_sent;  // Write data went out ahead of the address
    logic                     ready_to_requestor;
    logic aw_done, w_done, ar_done, r_done, b_done;

    // Lowest index wins
    always_comb begin
        sel_idx = '0;
        for (int ii = NUM_REQUESTORS - 1; ii >= 0; ii--) begin
            if (limp_valid[ii]) begin
                sel_idx = REQ_IDX_WIDTH'(ii);
            end
        end
    end

    assign any_valid = |limp_valid;
    assign cur_idx   = (state == IDLE) ? sel_idx : grant_q;  // Lock once out of IDLE

    assign cur_wen_nren = limp_wen_nren[cur_idx];
    assign cur_size     = limp_size[cur_idx];
    assign cur_addr     = limp_addr[cur_idx];
    assign cur_wdata    = limp_wdata[cur_idx];

    // Channel handshakes, responses must carry our ID
    assign aw_done = awvalid & awready;
    assign w_done  = wvalid & wready;
    assign ar_done = arvalid & arready;
    assign r_done  = rvalid & rready & (rid == AXI_ID);
    assign b_done  = bvalid & bready & (bid == AXI_ID);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state     <= IDLE;
            grant_q   <= '0;
            data_sent <= 1'b0;
        end else begin
            state <= next_state;
            if ((state == IDLE) && (next_state != IDLE)) begin
                grant_q <= sel_idx;
            end
            if (state == IDLE) begin
                data_sent <= w_done;
            end else if (w_done) begin
                data_sent <= 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (any_valid) begin
                    if (cur_wen_nren) begin
                        if (aw_done && w_done) next_state = GET_BRESP;
                        else if (aw_done)      next_state = SEND_WDATA;
                        else                   next_state = SEND_WADDR;  // Hold the grant
                    end else begin
                        if (ar_done && r_done) next_state = IDLE;        // Done in one cycle
                        else if (ar_done)      next_state = GET_RDATA;
                        else                   next_state = SEND_RADDR;
                    end
                end
            end
            SEND_RADDR: if (ar_done) next_state = GET_RDATA;
            GET_RDATA:  if (r_done)  next_state = IDLE;
            SEND_WADDR: begin
                if (aw_done && (data_sent || w_done)) next_state = GET_BRESP;
                else if (aw_done)                     next_state = SEND_WDATA;
            end
            SEND_WDATA: if (w_done) next_state = GET_BRESP;
            GET_BRESP:  if (b_done) next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    always_comb begin
        awvalid            = 1'b0;
        wvalid             = 1'b0;
        arvalid            = 1'b0;
        rready             = 1'b0;
        ready_to_requestor = 1'b0;
        unique case (state)
            IDLE: begin
                if (any_valid && cur_wen_nren) begin
                    awvalid = 1'b1;
                    wvalid  = 1'b1;
                end else if (any_valid) begin
                    arvalid            = 1'b1;
                    rready             = 1'b1;
                    ready_to_requestor = ar_done & r_done;
                end
            end
            SEND_RADDR: arvalid = 1'b1;
            GET_RDATA: begin
                rready             = 1'b1;
                ready_to_requestor = r_done;
            end
            SEND_WADDR: begin
                awvalid = 1'b1;
                wvalid  = ~data_sent;  // Keep offering data until taken
            end
            SEND_WDATA: wvalid = 1'b1;
            GET_BRESP:  ready_to_requestor = b_done;
            default: begin
            end
        endcase
    end

    // Ready only to the owner
    always_comb begin
        for (int ii = 0; ii < NUM_REQUESTORS; ii++) begin
            limp_ready[ii] = ready_to_requestor & (cur_idx == REQ_IDX_WIDTH'(ii));
        end
    end

    // Sub-word accesses go through strobes and lane muxing
    assign awaddr = {cur_addr[PADDR_WIDTH-1:2], 2'b00};
    assign araddr = {cur_addr[PADDR_WIDTH-1:2], 2'b00};

    letc_core_lane_fmt lane_fmt_inst (
        .size        (cur_size),
        .byte_offset (cur_addr[1:0]),
        .wdata_in    (cur_wdata),
        .axi_rdata   (rdata),
        .wstrb       (wstrb),
        .axi_wdata   (wdata),
        .rdata_out   (limp_rdata)
    );

    // Single beat, full word, one ID
    assign awid    = AXI_ID;
    assign arid    = AXI_ID;
    assign awlen   = '0;
    assign arlen   = '0;
    assign awsize  = AXI_SIZE_WORD;
    assign arsize  = AXI_SIZE_WORD;
    assign awburst = AXI_BURST_FIXED;
    assign arburst = AXI_BURST_FIXED;
    assign bready  = 1'b1;  // Response always taken at once

endmodule : letc_core_axi_fsm

`default_nettype wire

// ==== letc_axi_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module letc_axi_sram (
    input  logic i_clk,
    input  logic i_rst_n,

    // Back-pressure controls
    input  logic aw_stall,
    input  logic w_stall,
    input  logic ar_stall,
    input  logic r_stall,

    // AXI subordinate inputs
    input  logic [axi_pkg::IDWIDTH-1:0]  awid,
    input  letc_pkg::paddr_t             awaddr,
    input  logic [axi_pkg::LENWIDTH-1:0] awlen,
    input  logic [2:0]                   awsize,
    input  axi_pkg::burst_e              awburst,
    input  logic                         awvalid,
    input  letc_pkg::word_t              wdata,
    input  logic [3:0]                   wstrb,
    input  logic                         wvalid,
    input  logic                         bready,
    input  logic [axi_pkg::IDWIDTH-1:0]  arid,
    input  letc_pkg::paddr_t             araddr,
    input  logic [axi_pkg::LENWIDTH-1:0] arlen,
    input  logic [2:0]                   arsize,
    input  axi_pkg::burst_e              arburst,
    input  logic                         arvalid,
    input  logic                         rready,

    // AXI subordinate outputs
    output logic                         awready,
    output logic                         wready,
    output logic                         bvalid,
    output logic [axi_pkg::IDWIDTH-1:0]  bid,
    output logic [1:0]                   bresp,
    output logic                         arready,
    output logic                         rvalid,
    output logic [axi_pkg::IDWIDTH-1:0]  rid,
    output letc_pkg::word_t              rdata,
    output logic [1:0]                   rresp
);
    import letc_pkg::*;
    import axi_pkg::*;

    word_t  mem [MEM_WORDS];

    logic   aw_held, w_held;    // Write halves captured so far
    logic   rd_pending;         // Read data registered, not yet taken
    logic   r_shown;            // rvalid already up, must stay
    paddr_t awaddr_q;
    logic [IDWIDTH-1:0] awid_q;
    logic   aw_ok_q;
    word_t  wdata_q;
    logic [3:0] wstrb_q;
    logic   aw_hs, w_hs, ar_hs, wr_go;
    paddr_t wr_addr;
    logic [IDWIDTH-1:0] wr_id;
    logic   wr_ok;
    word_t  wr_data;
    logic [3:0] wr_strb;

    function automatic logic [$clog2(MEM_WORDS)-1:0] mem_idx(input paddr_t addr);
        mem_idx = addr[$clog2(MEM_WORDS)+1:2];  // Wraps above the array
    endfunction

    // Only single full-word beats are supported
    function automatic logic beat_ok(input logic [LENWIDTH-1:0] len, input logic [2:0] size,
                                     input burst_e burst);
        beat_ok = (len == '0) && (size == AXI_SIZE_WORD) && (burst != AXI_BURST_WRAP);
    endfunction

    assign awready = ~aw_stall & ~aw_held;
    assign wready  = ~w_stall & ~w_held;
    assign arready = ~ar_stall & ~rd_pending;
    assign rvalid  = rd_pending & (r_shown | ~r_stall);

    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign ar_hs = arvalid & arready;

    // Take each half from its register or straight off the bus
    assign wr_addr = aw_held ? awaddr_q : awaddr;
    assign wr_id   = aw_held ? awid_q : awid;
    assign wr_ok   = aw_held ? aw_ok_q : beat_ok(awlen, awsize, awburst);
    assign wr_data = w_held ? wdata_q : wdata;
    assign wr_strb = w_held ? wstrb_q : wstrb;
    assign wr_go   = (aw_held | aw_hs) & (w_held | w_hs) & ~bvalid;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            aw_held    <= 1'b0;
            w_held     <= 1'b0;
            bvalid     <= 1'b0;
            rd_pending <= 1'b0;
            r_shown    <= 1'b0;
            for (int ii = 0; ii < MEM_WORDS; ii++) begin
                mem[ii] <= '0;
            end
        end else begin
            if (wr_go) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                for (int bb = 0; bb < 4; bb++) begin
                    if (wr_ok && wr_strb[bb]) begin
                        mem[mem_idx(wr_addr)][8*bb +: 8] <= wr_data[8*bb +: 8];
                    end
                end
            end else begin
                if (aw_hs) aw_held <= 1'b1;
                if (w_hs) w_held <= 1'b1;
                if (bvalid && bready) bvalid <= 1'b0;  // One cycle with bready high
            end
            if (ar_hs) begin
                rd_pending <= 1'b1;
            end else if (rvalid && rready) begin
                rd_pending <= 1'b0;
            end
            r_shown <= rvalid & ~rready;
        end
    end

    // Payload registers
    always_ff @(posedge i_clk) begin
        if (aw_hs) begin
            awaddr_q <= awaddr;
            awid_q   <= awid;
            aw_ok_q  <= beat_ok(awlen, awsize, awburst);
        end
        if (w_hs) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (wr_go) begin
            bid   <= wr_id;
            bresp <= wr_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
        if (ar_hs) begin
            rdata <= mem[mem_idx(araddr)];
            rid   <= arid;
            rresp <= beat_ok(arlen, arsize, arburst) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
    end

endmodule : letc_axi_sram

`default_nettype wire

// ==== letc_core_axi_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module letc_core_axi_subsys (
    input  logic i_clk,
    input  logic i_rst_n,

    // Requestor lanes
    input  logic [letc_pkg::NUM_REQUESTORS-1:0]              limp_valid,
    input  logic [letc_pkg::NUM_REQUESTORS-1:0]              limp_wen_nren,
    input  letc_pkg::size_e [letc_pkg::NUM_REQUESTORS-1:0]   limp_size,
    input  letc_pkg::paddr_t [letc_pkg::NUM_REQUESTORS-1:0]  limp_addr,
    input  letc_pkg::word_t [letc_pkg::NUM_REQUESTORS-1:0]   limp_wdata,
    output logic [letc_pkg::NUM_REQUESTORS-1:0]              limp_ready,
    output letc_pkg::word_t                                  limp_rdata,

    // Subordinate throttling
    input  logic aw_stall,
    input  logic w_stall,
    input  logic ar_stall,
    input  logic r_stall
);
    import letc_pkg::*;
    import axi_pkg::*;

    // AXI between manager and memory
    logic [IDWIDTH-1:0]  awid, bid, arid, rid;
    paddr_t              awaddr, araddr;
    logic [LENWIDTH-1:0] awlen, arlen;
    logic [2:0]          awsize, arsize;
    burst_e              awburst, arburst;
    word_t               wdata, rdata;
    logic [3:0]          wstrb;
    logic [1:0]          bresp, rresp;
    logic                awvalid, awready, wvalid, wready, bvalid, bready;
    logic                arvalid, arready, rvalid, rready;

    // Names match on both sides
    letc_core_axi_fsm axi_fsm_inst (.*);

    letc_axi_sram axi_sram_inst (.*);

endmodule : letc_core_axi_subsys

`default_nettype wire

// ==== tb_letc_core_axi_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_letc_core_axi_subsys;
    import letc_pkg::*;

    logic i_clk;
    logic i_rst_n;

    logic [NUM_REQUESTORS-1:0]   limp_valid;
    logic [NUM_REQUESTORS-1:0]   limp_wen_nren;
    size_e [NUM_REQUESTORS-1:0]  limp_size;
    paddr_t [NUM_REQUESTORS-1:0] limp_addr;
    word_t [NUM_REQUESTORS-1:0]  limp_wdata;
    logic [NUM_REQUESTORS-1:0]   limp_ready;
    word_t                       limp_rdata;
    logic aw_stall, w_stall, ar_stall, r_stall;

    word_t shadow [MEM_WORDS];  // Mirror of the subordinate memory
    string test_name;

    // Pending request per requestor for the next group
    logic [NUM_REQUESTORS-1:0] act_en;
    logic   act_wr    [NUM_REQUESTORS];
    size_e  act_size  [NUM_REQUESTORS];
    paddr_t act_addr  [NUM_REQUESTORS];
    word_t  act_wdata [NUM_REQUESTORS];
    int     act_start [NUM_REQUESTORS];  // Cycle at which valid rises
    int     done_order [$];

    letc_core_axi_subsys letc_core_axi_subsys_inst (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;  // 8 ns period
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_stop($sformatf("error %s / %s: expected %h actual %h",
                                test_name, what, exp, act));
        end
    endtask

    // Zero extended byte, halfword or word from the shadow
    function automatic word_t ref_read(input size_e size, input paddr_t addr);
        word_t w;
        w = shadow[addr[9:2]];
        case (size)
            SIZE_BYTE:     ref_read = (w >> (8 * addr[1:0])) & 32'h0000_00ff;
            SIZE_HALFWORD: ref_read = (w >> (addr[1] ? 16 : 0)) & 32'h0000_ffff;
            default:       ref_read = w;
        endcase
    endfunction

    // Low bytes of data land at the addressed lanes
    task automatic ref_write(input size_e size, input paddr_t addr, input word_t data);
        int lo;
        int n;
        lo = (size == SIZE_BYTE) ? int'(addr[1:0]) : (size == SIZE_HALFWORD && addr[1]) ? 2 : 0;
        n  = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALFWORD) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            shadow[addr[9:2]][8*(lo+b) +: 8] = data[8*b +: 8];
        end
    endtask

    // Random address in a 16 word window whose upper bits exercise the wrap
    function automatic paddr_t rand_addr(input size_e size);
        paddr_t a;
        a = $urandom;
        a[9:6] = 4'h0;
        if (size == SIZE_HALFWORD) a[0] = 1'b0;
        else if (size == SIZE_WORD) a[1:0] = 2'b00;
        return a;
    endfunction

    task automatic apply_stalls(input logic [3:0] m);
        aw_stall = m[3];
        w_stall  = m[2];
        ar_stall = m[1];
        r_stall  = m[0];
    endtask

    task automatic clear_reqs();
        act_en = '0;
    endtask

    task automatic set_req(input int r, input logic wr, input size_e size, input paddr_t addr,
                           input word_t wdata, input int start);
        act_en[r]    = 1'b1;
        act_wr[r]    = wr;
        act_size[r]  = size;
        act_addr[r]  = addr;
        act_wdata[r] = wdata;
        act_start[r] = start;
    endtask

    // Runs all pending requests and returns on a falling edge
    task automatic run_group(input bit rand_stall, input int hold, input logic [3:0] hold_mask,
                             input int exp_lat);
        logic [NUM_REQUESTORS-1:0] left;
        logic [NUM_REQUESTORS-1:0] seen;
        logic [NUM_REQUESTORS-1:0] now_done;
        int cyc;
        int quiet;
        left  = act_en;
        seen  = '0;
        cyc   = 0;
        quiet = 0;
        done_order.delete();
        while (1) begin
            limp_valid = limp_valid & ~seen;  // Requestors served at the last edge let go
            if (left == '0) break;
            for (int r = 0; r < NUM_REQUESTORS; r++) begin
                if (left[r] && !limp_valid[r] && cyc == act_start[r]) begin
                    limp_valid[r]    = 1'b1;
                    limp_wen_nren[r] = act_wr[r];
                    limp_size[r]     = act_size[r];
                    limp_addr[r]     = act_addr[r];
                    limp_wdata[r]    = act_wdata[r];
                end
            end
            if (cyc < hold) apply_stalls(hold_mask);
            else if (rand_stall) apply_stalls(4'($urandom) & 4'($urandom));
            else apply_stalls(4'b0000);
            @(posedge i_clk);
            now_done = limp_ready;  // Values the FSM acts on at this edge
            check_value("ready one-hot", 1, $onehot0(now_done));
            check_value("ready to non-owner", 0, now_done & ~left);
            for (int r = 0; r < NUM_REQUESTORS; r++) begin
                if (now_done[r]) begin
                    if (act_wr[r]) ref_write(act_size[r], act_addr[r], act_wdata[r]);
                    else check_value("read data", ref_read(act_size[r], act_addr[r]), limp_rdata);
                    if (exp_lat > 0) check_value("ready latency", exp_lat, cyc - act_start[r]);
                    done_order.push_back(r);
                end
            end
            left  = left & ~now_done;
            seen  = now_done;
            quiet = (now_done != '0) ? 0 : quiet + 1;
            if (quiet > 200) fail_stop("timeout: no ready pulse arrived within 200 cycles");
            @(negedge i_clk);
            cyc++;
        end
    endtask

    task automatic single_access(input int r, input logic wr, input size_e size,
                                 input paddr_t addr, input word_t wdata, input int exp_lat);
        clear_reqs();
        set_req(r, wr, size, addr, wdata, 0);
        run_group(1'b0, 0, 4'b0000, exp_lat);
    endtask

    initial begin
        int unsigned seed_val;
        size_e sz;
        paddr_t base;
        int rq;
        int nreq;
        logic [2:0] mask;
        seed_val = $urandom(60);
        i_rst_n       = 1'b0;
        limp_valid    = '0;
        limp_wen_nren = '0;
        limp_size     = '0;
        limp_addr     = '0;
        limp_wdata    = '0;
        apply_stalls(4'b0000);
        clear_reqs();
        foreach (shadow[i]) shadow[i] = '0;
        repeat (8) @(negedge i_clk);
        i_rst_n = 1'b1;

        test_name = "after reset";
        repeat (10) begin
            @(negedge i_clk);
            check_value("idle ready", 0, limp_ready);
        end
        single_access(0, 1'b0, SIZE_WORD, $urandom & ~32'h3, '0, 1);

        test_name = "unstalled sizes";
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                sz = size_e'(s);
                if ((sz == SIZE_HALFWORD && off % 2 != 0) ||
                    (sz == SIZE_WORD && off != 0)) continue;
                base = $urandom & ~32'h3;
                rq   = $urandom_range(0, 2);
                single_access(rq, 1'b1, sz, base + off, $urandom, 1);
                single_access(rq, 1'b0, SIZE_WORD, base, '0, 1);
                single_access(rq, 1'b0, SIZE_HALFWORD, base + (off & 2), '0, 1);
                single_access(rq, 1'b0, SIZE_BYTE, base + off, '0, 1);
            end
        end

        test_name = "priority";
        clear_reqs();
        for (int r = 0; r < NUM_REQUESTORS; r++) begin
            sz = size_e'($urandom_range(0, 2));
            set_req(r, $urandom_range(0, 1), sz, rand_addr(sz), $urandom, 0);
        end
        run_group(1'b0, 0, 4'b0000, 0);
        check_value("first grant", 0, done_order[0]);
        check_value("second grant", 1, done_order[1]);
        check_value("third grant", 2, done_order[2]);

        // Requestor 0 arrives while 2 sits in SEND_RADDR
        test_name = "grant lock";
        clear_reqs();
        set_req(2, 1'b0, SIZE_WORD, rand_addr(SIZE_WORD), '0, 0);
        set_req(0, 1'b1, SIZE_HALFWORD, rand_addr(SIZE_HALFWORD), $urandom, 1);
        run_group(1'b0, 4, 4'b1111, 0);
        check_value("locked owner first", 2, done_order[0]);
        check_value("newcomer second", 0, done_order[1]);

        test_name = "random stalls";
        nreq = 0;
        while (nreq < 300) begin
            clear_reqs();
            mask = 3'($urandom_range(1, 7));
            for (int r = 0; r < NUM_REQUESTORS; r++) begin
                if (mask[r]) begin
                    sz = size_e'($urandom_range(0, 2));
                    set_req(r, $urandom_range(0, 1), sz, rand_addr(sz), $urandom,
                            $urandom_range(0, 3));
                    nreq++;
                end
            end
            run_group(1'b1, 0, 4'b0000, 0);
        end

        test_name = "aw stalled";
        base = rand_addr(SIZE_WORD);
        clear_reqs();
        set_req(1, 1'b1, SIZE_WORD, base, $urandom, 0);
        run_group(1'b0, 4, 4'b1000, 0);  // Data taken first and the address later in SEND_WADDR
        single_access(1, 1'b0, SIZE_WORD, base, '0, 1);

        test_name = "w stalled";
        clear_reqs();
        set_req(2, 1'b1, SIZE_BYTE, base + 3, $urandom, 0);
        run_group(1'b0, 4, 4'b0100, 0);  // Address taken first and data later in SEND_WDATA
        single_access(2, 1'b0, SIZE_WORD, base, '0, 1);

        test_name = "ar stalled";
        clear_reqs();
        set_req(0, 1'b0, SIZE_HALFWORD, base + 2, '0, 0);
        run_group(1'b0, 4, 4'b0010, 0);
        single_access(0, 1'b0, SIZE_WORD, base, '0, 1);

        $display("Result: PASSED");
        $finish;
    end

endmodule : tb_letc_core_axi_subsys

`default_nettype wire

// ==== list.f ====
letc_pkg.sv
axi_pkg.sv
letc_core_lane_fmt.sv
letc_core_axi_fsm.sv
letc_axi_sram.sv
letc_core_axi_subsys.sv
tb_letc_core_axi_subsys.sv

// ==== Bender.yml ====
package:
  name: letc_core_axi_subsys

sources:
  - letc_pkg.sv
  - axi_pkg.sv
  - letc_core_lane_fmt.sv
  - letc_core_axi_fsm.sv
  - letc_axi_sram.sv
  - letc_core_axi_subsys.sv
  - target: test
    files:
      - tb_letc_core_axi_subsys.sv
